// File: design/eth_buf_pkg.sv
`default_nettype none

package eth_buf_pkg;

   // Frame ring
   localparam int unsigned num_slots = 4;
   localparam int unsigned slot_idx_w = 2;

   // One slot holds a full 2 KB frame
   localparam int unsigned slot_addr_w = 11;
   localparam int unsigned len_w = 11;

   // Status counters
   localparam int unsigned cnt_w = 16;

endpackage

`default_nettype wire

// File: design/eth_crc32.sv
`timescale 1ns/1ns
`default_nettype none

module eth_crc32 (
   input  wire logic       RX_CLK,
   input  wire logic       ETH_PHY_RESETN,
   input  wire logic       frame_start,
   input  wire logic       byte_valid,
   input  wire logic [7:0] byte_data,
   input  wire logic       frame_end,
   output logic            crc_ok
);
   import eth_frame_pkg::*;

   logic [31:0] crc;

   // One byte through the reflected LFSR, LSB first
   function automatic logic [31:0] crc_next(input logic [31:0] c, input logic [7:0] d);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (r[0] ^ d[i]) begin
            r = (r >> 1) ^ crc_poly;
         end else begin
            r = r >> 1;
         end
      end
      return r;
   endfunction

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc    <= '1;
         crc_ok <= 1'b0;
      end else begin
         if (byte_valid) begin
            crc <= crc_next(frame_start ? '1 : crc, byte_data);
         end
         // FCS included, so a clean frame leaves the fixed residue
         if (frame_end) begin
            crc_ok <= (crc == crc_residue);
         end
      end
   end

endmodule

`default_nettype wire

// File: design/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

   // Station address, first byte on the wire in the top octet
   localparam logic [47:0] station_mac = 48'h02_00_5e_10_20_30;
   localparam logic [47:0] bcast_mac = 48'hff_ff_ff_ff_ff_ff;

   // MII nibbles, low nibble first on the wire
   localparam logic [3:0] preamble_nibble = 4'h5;
   localparam logic [3:0] sfd_nibble = 4'hd;

   // Reflected CRC-32 and the remainder left by a frame with a good FCS
   localparam logic [31:0] crc_poly = 32'hedb8_8320;
   localparam logic [31:0] crc_residue = 32'hdebb_20e3;

   // Lengths count destination through FCS
   localparam int unsigned min_frame_bytes = 64;
   localparam int unsigned max_frame_bytes = 1518;
   localparam int unsigned fcs_bytes = 4;

endpackage

`default_nettype wire

// File: design/eth_rx_drain.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_drain (
   input  wire logic                                RX_CLK,
   input  wire logic                                ETH_PHY_RESETN,
   eth_slot_if.reader                               slot [eth_buf_pkg::num_slots],
   input  wire logic [eth_buf_pkg::slot_addr_w-1:0] rd_addr,
   input  wire logic                                rcv_ack,
   output logic                                     frame_avail,
   output logic [eth_buf_pkg::len_w-1:0]            frame_len,
   output logic [7:0]                               rd_data
);
   import eth_buf_pkg::*;

   logic [slot_idx_w-1:0] rd_ptr;
   logic [num_slots-1:0]  full_vec;
   logic [len_w-1:0]      len_vec [num_slots];
   logic [7:0]            data_vec [num_slots];
   logic                  ack;

   // Ack without a presented frame does nothing
   assign ack = rcv_ack && frame_avail;

   for (genvar i = 0; i < num_slots; i++) begin : g_slot
      assign full_vec[i]          = slot[i].full;
      assign len_vec[i]           = slot[i].len;
      assign data_vec[i]          = slot[i].rd_data;
      assign slot[i].rd_addr      = rd_addr;
      assign slot[i].release_slot = ack && (rd_ptr == slot_idx_w'(i));
   end

   assign frame_len = len_vec[rd_ptr];
   assign rd_data   = data_vec[rd_ptr];

   // Same ring order as the writer
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         rd_ptr      <= '0;
         frame_avail <= 1'b0;
      end else if (ack) begin
         rd_ptr      <= rd_ptr + 1'b1;
         frame_avail <= 1'b0;
      end else begin
         frame_avail <= full_vec[rd_ptr];
      end
   end

endmodule

`default_nettype wire

// File: design/eth_rx_frame_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_frame_ctrl (
   input  wire logic                        RX_CLK,
   input  wire logic                        ETH_PHY_RESETN,
   input  wire logic                        frame_start,
   input  wire logic                        byte_valid,
   input  wire logic [7:0]                  byte_data,
   input  wire logic                        frame_end,
   input  wire logic                        crc_ok,
   eth_slot_if.writer                       slot [eth_buf_pkg::num_slots],
   output logic [eth_buf_pkg::cnt_w-1:0]    rx_frame_count,
   output logic [eth_buf_pkg::cnt_w-1:0]    drop_addr_count,
   output logic [eth_buf_pkg::cnt_w-1:0]    drop_crc_count,
   output logic [eth_buf_pkg::cnt_w-1:0]    drop_full_count
);
   import eth_frame_pkg::*;
   import eth_buf_pkg::*;

   logic [slot_idx_w-1:0] wr_ptr;
   logic [slot_idx_w-1:0] commit_idx;
   logic [num_slots-1:0]  full_vec;
   logic                  in_frame;
   logic                  claimed;
   logic                  too_long;
   logic                  eval;
   logic                  commit_q;
   logic [len_w-1:0]      commit_len_q;
   logic [len_w-1:0]      byte_cnt;
   logic [len_w-1:0]      cur_cnt;
   logic                  cur_claim;
   logic                  wr_en;
   logic [47:0]           dest;
   logic                  addr_ok;
   logic                  len_ok;

   for (genvar i = 0; i < num_slots; i++) begin : g_slot
      assign full_vec[i]        = slot[i].full;
      assign slot[i].wr         = wr_en && (wr_ptr == slot_idx_w'(i));
      assign slot[i].wr_addr    = slot_addr_w'(cur_cnt);
      assign slot[i].wr_data    = byte_data;
      assign slot[i].commit     = commit_q && (commit_idx == slot_idx_w'(i));
      assign slot[i].commit_len = commit_len_q;
   end

   // First byte decides whether this frame owns a slot
   assign cur_cnt   = frame_start ? '0 : byte_cnt;
   assign cur_claim = frame_start ? !full_vec[wr_ptr] : claimed;
   assign wr_en     = byte_valid && cur_claim && (cur_cnt != len_w'(max_frame_bytes));

   // Full destination must have arrived
   assign addr_ok = (byte_cnt >= len_w'(6)) && ((dest == station_mac) || (dest == bcast_mac));
   assign len_ok  = !too_long && (byte_cnt >= len_w'(min_frame_bytes));

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         wr_ptr          <= '0;
         commit_idx      <= '0;
         in_frame        <= 1'b0;
         claimed         <= 1'b0;
         too_long        <= 1'b0;
         eval            <= 1'b0;
         commit_q        <= 1'b0;
         byte_cnt        <= '0;
         rx_frame_count  <= '0;
         drop_addr_count <= '0;
         drop_crc_count  <= '0;
         drop_full_count <= '0;
      end else begin
         commit_q <= 1'b0;
         eval     <= frame_end && in_frame;
         if (frame_start) begin
            too_long <= 1'b0;
         end
         if (byte_valid) begin
            in_frame <= 1'b1;
            claimed  <= cur_claim;
            if (cur_cnt == len_w'(max_frame_bytes)) begin
               too_long <= 1'b1;
            end else begin
               byte_cnt <= cur_cnt + 1'b1;
            end
         end
         if (frame_end) begin
            in_frame <= 1'b0;
         end
         // crc_ok settles one cycle after frame_end
         if (eval) begin
            if (!claimed) begin
               drop_full_count <= drop_full_count + 1'b1;
            end else if (!addr_ok) begin
               drop_addr_count <= drop_addr_count + 1'b1;
            end else if (!crc_ok || !len_ok) begin
               drop_crc_count <= drop_crc_count + 1'b1;
            end else begin
               commit_q       <= 1'b1;
               commit_idx     <= wr_ptr;
               wr_ptr         <= wr_ptr + 1'b1;
               rx_frame_count <= rx_frame_count + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (byte_valid && (cur_cnt < len_w'(6))) begin
         dest <= {dest[39:0], byte_data};
      end
      if (eval) begin
         commit_len_q <= byte_cnt - len_w'(fcs_bytes);
      end
   end

endmodule

`default_nettype wire

// File: design/eth_rx_slot.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_slot (
   input  wire logic  RX_CLK,
   input  wire logic  ETH_PHY_RESETN,
   eth_slot_if.store  slot
);
   import eth_buf_pkg::*;

   logic [7:0] mem [2**slot_addr_w];

   // Byte store, one write and one registered read port
   always_ff @(posedge RX_CLK) begin
      if (slot.wr) begin
         mem[slot.wr_addr] <= slot.wr_data;
      end
      slot.rd_data <= mem[slot.rd_addr];
   end

   always_ff @(posedge RX_CLK) begin
      if (slot.commit) begin
         slot.len <= slot.commit_len;
      end
   end

   // Owned by the drain from commit until release
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         slot.full <= 1'b0;
      end else if (slot.commit) begin
         slot.full <= 1'b1;
      end else if (slot.release_slot) begin
         slot.full <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: design/eth_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_top (
   input  wire logic                                RX_CLK,
   input  wire logic                                ETH_PHY_RESETN,
   input  wire logic                                RX_DV,
   input  wire logic [3:0]                          RX_DATA,
   input  wire logic [eth_buf_pkg::slot_addr_w-1:0] rd_addr,
   input  wire logic                                rcv_ack,
   output logic                                     frame_avail,
   output logic [eth_buf_pkg::len_w-1:0]            frame_len,
   output logic [7:0]                               rd_data,
   output logic                                     phy_dv_detected,
   output logic [eth_buf_pkg::cnt_w-1:0]            rx_frame_count,
   output logic [eth_buf_pkg::cnt_w-1:0]            drop_addr_count,
   output logic [eth_buf_pkg::cnt_w-1:0]            drop_crc_count,
   output logic [eth_buf_pkg::cnt_w-1:0]            drop_full_count
);
   import eth_buf_pkg::*;

   logic       byte_valid;
   logic [7:0] byte_data;
   logic       frame_start;
   logic       frame_end;
   logic       crc_ok;

   eth_slot_if slot_bus [num_slots] ();

   mii_rx_deframer u_deframer (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .rx_dv          (RX_DV),
      .rx_data        (RX_DATA),
      .byte_valid     (byte_valid),
      .byte_data      (byte_data),
      .frame_start    (frame_start),
      .frame_end      (frame_end)
   );

   eth_crc32 u_crc (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .frame_start    (frame_start),
      .byte_valid     (byte_valid),
      .byte_data      (byte_data),
      .frame_end      (frame_end),
      .crc_ok         (crc_ok)
   );

   eth_rx_frame_ctrl u_ctrl (
      .RX_CLK          (RX_CLK),
      .ETH_PHY_RESETN  (ETH_PHY_RESETN),
      .frame_start     (frame_start),
      .byte_valid      (byte_valid),
      .byte_data       (byte_data),
      .frame_end       (frame_end),
      .crc_ok          (crc_ok),
      .slot            (slot_bus),
      .rx_frame_count  (rx_frame_count),
      .drop_addr_count (drop_addr_count),
      .drop_crc_count  (drop_crc_count),
      .drop_full_count (drop_full_count)
   );

   for (genvar i = 0; i < num_slots; i++) begin : g_slot
      eth_rx_slot u_slot (
         .RX_CLK         (RX_CLK),
         .ETH_PHY_RESETN (ETH_PHY_RESETN),
         .slot           (slot_bus[i])
      );
   end

   eth_rx_drain u_drain (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .slot           (slot_bus),
      .rd_addr        (rd_addr),
      .rcv_ack        (rcv_ack),
      .frame_avail    (frame_avail),
      .frame_len      (frame_len),
      .rd_data        (rd_data)
   );

   // Sticky until reset
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         phy_dv_detected <= 1'b0;
      end else if (RX_DV) begin
         phy_dv_detected <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: design/eth_slot_if.sv
`timescale 1ns/1ns
`default_nettype none

interface eth_slot_if;
   import eth_buf_pkg::*;

   // Fill side
   logic                   wr;
   logic [slot_addr_w-1:0] wr_addr;
   logic [7:0]             wr_data;
   logic                   commit;
   logic [len_w-1:0]       commit_len;

   // Drain side
   logic [slot_addr_w-1:0] rd_addr;
   logic                   release_slot;
   logic [7:0]             rd_data;
   logic [len_w-1:0]       len;

   logic                   full;

   modport writer (output wr, wr_addr, wr_data, commit, commit_len, input full);

   modport store (input wr, wr_addr, wr_data, commit, commit_len, rd_addr, release_slot,
                  output full, rd_data, len);

   modport reader (output rd_addr, release_slot, input full, len, rd_data);

endinterface

`default_nettype wire

// File: design/mii_rx_deframer.sv
`timescale 1ns/1ns
`default_nettype none

module mii_rx_deframer (
   input  wire logic       RX_CLK,
   input  wire logic       ETH_PHY_RESETN,
   input  wire logic       rx_dv,
   input  wire logic [3:0] rx_data,
   output logic            byte_valid,
   output logic [7:0]      byte_data,
   output logic            frame_start,
   output logic            frame_end
);
   import eth_frame_pkg::*;

   typedef enum logic [1:0] {st_idle, st_pre, st_data, st_wait} state_t;

   state_t     state;
   logic       half;
   logic       first;
   logic [3:0] low_nib;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state       <= st_idle;
         half        <= 1'b0;
         first       <= 1'b0;
         byte_valid  <= 1'b0;
         frame_start <= 1'b0;
         frame_end   <= 1'b0;
      end else begin
         byte_valid  <= 1'b0;
         frame_start <= 1'b0;
         frame_end   <= 1'b0;
         case (state)
            st_idle: begin
               if (rx_dv) begin
                  state <= (rx_data == preamble_nibble) ? st_pre : st_wait;
               end
            end
            st_pre: begin
               if (!rx_dv) begin
                  // No delimiter seen, so no frame_end either
                  state <= st_idle;
               end else if (rx_data == sfd_nibble) begin
                  state <= st_data;
                  half  <= 1'b0;
                  first <= 1'b1;
               end else if (rx_data != preamble_nibble) begin
                  state <= st_wait;
               end
            end
            st_data: begin
               if (!rx_dv) begin
                  // A dangling low nibble is simply lost here
                  frame_end <= 1'b1;
                  state     <= st_idle;
               end else if (!half) begin
                  half <= 1'b1;
               end else begin
                  half        <= 1'b0;
                  byte_valid  <= 1'b1;
                  frame_start <= first;
                  first       <= 1'b0;
               end
            end
            default: begin
               // Garbage burst, wait for carrier to drop
               if (!rx_dv) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (state == st_data && rx_dv) begin
         if (!half) begin
            low_nib <= rx_data;
         end else begin
            byte_data <= {rx_data, low_nib};
         end
      end
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tb
design/eth_frame_pkg.sv
design/eth_buf_pkg.sv
design/eth_slot_if.sv
design/mii_rx_deframer.sv
design/eth_crc32.sv
design/eth_rx_frame_ctrl.sv
design/eth_rx_slot.sv
design/eth_rx_drain.sv
design/eth_rx_top.sv
tb/tb_eth_rx.sv

// File: tb/tb_eth_rx_frames.svh
`ifndef TB_ETH_RX_FRAMES_SVH
`define TB_ETH_RX_FRAMES_SVH

// Source address used for every test frame
localparam logic [47:0] src_mac = 48'h02_aa_bb_cc_dd_01;

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] r;
   r = x;
   r = r ^ (r << 13);
   r = r ^ (r >> 17);
   r = r ^ (r << 5);
   return r;
endfunction

// Reference CRC-32, byte folded in first, then eight shifts
function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
   logic [31:0] c;
   c = crc ^ {24'h0, b};
   for (int k = 0; k < 8; k++) begin
      c = (c >> 1) ^ (32'hedb8_8320 & {32{c[0]}});
   end
   return c;
endfunction

// Fills tx_q with dest, source, payload and FCS
task automatic build_frame(input logic [47:0] dest, input int payload_len,
                           input bit corrupt, input bit keep);
   logic [31:0] crc;
   tx_q.delete();
   for (int i = 5; i >= 0; i--) begin
      tx_q.push_back(dest[8*i +: 8]);
   end
   for (int i = 5; i >= 0; i--) begin
      tx_q.push_back(src_mac[8*i +: 8]);
   end
   for (int i = 0; i < payload_len; i++) begin
      rng_state = xorshift32(rng_state);
      tx_q.push_back(rng_state[7:0]);
   end
   // Expected host view excludes the FCS
   if (keep) begin
      foreach (tx_q[i]) begin
         stored_q.push_back(tx_q[i]);
      end
      len_q.push_back(tx_q.size());
   end
   crc = 32'hffff_ffff;
   foreach (tx_q[i]) begin
      crc = crc_byte(crc, tx_q[i]);
   end
   crc = ~crc;
   for (int i = 0; i < 4; i++) begin
      tx_q.push_back(crc[8*i +: 8]);
   end
   if (corrupt) begin
      tx_q[tx_q.size() - 2] = tx_q[tx_q.size() - 2] ^ 8'h10;
   end
endtask

// Called on a falling edge, holds the nibble for one cycle
task automatic send_nibble(input logic [3:0] n);
   rx_dv   = 1'b1;
   rx_data = n;
   @(negedge RX_CLK);
endtask

task automatic send_frame();
   // Seven preamble bytes plus the low half of the delimiter
   for (int i = 0; i < 15; i++) begin
      send_nibble(4'h5);
   end
   send_nibble(4'hd);
   foreach (tx_q[i]) begin
      send_nibble(tx_q[i][3:0]);
      send_nibble(tx_q[i][7:4]);
   end
   rx_dv   = 1'b0;
   rx_data = 4'h0;
   // Inter-frame gap
   repeat (12) @(negedge RX_CLK);
endtask

`endif

// File: tb/tb_eth_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eth_rx;
   import eth_frame_pkg::*;
   import eth_buf_pkg::*;

   localparam int avail_timeout = 32;

   logic                   RX_CLK;
   logic                   ETH_PHY_RESETN;
   logic                   rx_dv;
   logic [3:0]             rx_data;
   logic [slot_addr_w-1:0] rd_addr;
   logic                   rcv_ack;
   logic                   frame_avail;
   logic [len_w-1:0]       frame_len;
   logic [7:0]             rd_data;
   logic                   phy_dv_detected;
   logic [cnt_w-1:0]       rx_frame_count;
   logic [cnt_w-1:0]       drop_addr_count;
   logic [cnt_w-1:0]       drop_crc_count;
   logic [cnt_w-1:0]       drop_full_count;
   logic [num_slots-1:0]   full_seen;

   logic [7:0]  tx_q [$];
   logic [7:0]  stored_q [$];
   int          len_q [$];
   logic [31:0] rng_state = 32'd1;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          exp_rx = 0;
   int          exp_addr = 0;
   int          exp_crc = 0;
   int          exp_full = 0;

   `include "tb_eth_rx_frames.svh"

   eth_rx_top uut (
      .RX_CLK          (RX_CLK),
      .ETH_PHY_RESETN  (ETH_PHY_RESETN),
      .RX_DV           (rx_dv),
      .RX_DATA         (rx_data),
      .rd_addr         (rd_addr),
      .rcv_ack         (rcv_ack),
      .frame_avail     (frame_avail),
      .frame_len       (frame_len),
      .rd_data         (rd_data),
      .phy_dv_detected (phy_dv_detected),
      .rx_frame_count  (rx_frame_count),
      .drop_addr_count (drop_addr_count),
      .drop_crc_count  (drop_crc_count),
      .drop_full_count (drop_full_count)
   );

   for (genvar g = 0; g < num_slots; g++) begin : g_full
      assign full_seen[g] = uut.slot_bus[g].full;
   end

   initial begin
      RX_CLK = 1'b0;
      forever #2 RX_CLK = ~RX_CLK;
   end

   ack_clears_avail: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      rcv_ack && frame_avail |=> !frame_avail)
   else begin
      $display("Fail at %0t ns: frame_avail still high after rcv_ack", $time);
      errors++;
   end

   // A fresh commit cannot land while a frame is still arriving
   no_rise_in_rx: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      rx_dv && $rose(frame_avail) |-> $past(|full_seen, 2))
   else begin
      $display("Fail at %0t ns: frame_avail rose during RX_DV with no slot full", $time);
      errors++;
   end

   dv_sticky: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      phy_dv_detected |=> phy_dv_detected)
   else begin
      $display("Fail at %0t ns: phy_dv_detected dropped", $time);
      errors++;
   end

   task automatic expect_eq(input int actual, input int expected, input string what);
      checks++;
      assert (actual == expected)
      else begin
         $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
         errors++;
      end
   endtask

   task automatic check_counters();
      expect_eq(rx_frame_count, exp_rx, "rx_frame_count");
      expect_eq(drop_addr_count, exp_addr, "drop_addr_count");
      expect_eq(drop_crc_count, exp_crc, "drop_crc_count");
      expect_eq(drop_full_count, exp_full, "drop_full_count");
   endtask

   task automatic wait_avail(input string what);
      int n;
      n = 0;
      while (!frame_avail && n < avail_timeout) begin
         @(negedge RX_CLK);
         n++;
      end
      if (!frame_avail) begin
         $display("Timeout: frame_avail did not rise within %0d cycles for %s",
                  avail_timeout, what);
         errors++;
      end
   endtask

   // Compares length and every byte with the oldest expected frame
   task automatic read_frame(input string what);
      int         len;
      logic [7:0] exp_byte;
      len = len_q.pop_front();
      expect_eq(frame_len, len, {what, " frame_len"});
      for (int i = 0; i < len; i++) begin
         rd_addr = slot_addr_w'(i);
         @(negedge RX_CLK);
         exp_byte = stored_q.pop_front();
         expect_eq(rd_data, exp_byte, {what, " data byte"});
      end
   endtask

   task automatic ack_frame(input string what);
      rcv_ack = 1'b1;
      @(negedge RX_CLK);
      rcv_ack = 1'b0;
      expect_eq(frame_avail, 0, {what, " frame_avail after ack"});
   endtask

   task automatic report_test(input string name, input int mark);
      tests++;
      if (errors == mark) begin
         $display("Test %0d %s: ok", tests, name);
      end else begin
         $display("Test %0d %s: failed, %0d errors", tests, name, errors - mark);
      end
   endtask

   initial begin
      int mark;
      ETH_PHY_RESETN = 1'b0;
      rx_dv          = 1'b0;
      rx_data        = 4'h0;
      rd_addr        = '0;
      rcv_ack        = 1'b0;
      repeat (4) @(negedge RX_CLK);
      ETH_PHY_RESETN = 1'b1;
      @(negedge RX_CLK);

      mark = errors;
      expect_eq(frame_avail, 0, "frame_avail after reset");
      expect_eq(phy_dv_detected, 0, "phy_dv_detected after reset");
      check_counters();
      // Short carrier burst with no preamble
      send_nibble(4'h0);
      rx_dv = 1'b0;
      repeat (3) @(negedge RX_CLK);
      expect_eq(phy_dv_detected, 1, "phy_dv_detected after RX_DV");
      report_test("reset and carrier", mark);

      mark = errors;
      build_frame(station_mac, 48, 1'b0, 1'b1);
      send_frame();
      exp_rx++;
      wait_avail("station frame");
      expect_eq(frame_len, tx_q.size() - 4, "frame_len vs bytes sent");
      read_frame("station frame");
      check_counters();
      ack_frame("station frame");
      report_test("station frame", mark);

      mark = errors;
      build_frame(bcast_mac, 50, 1'b0, 1'b1);
      send_frame();
      exp_rx++;
      wait_avail("broadcast frame");
      read_frame("broadcast frame");
      ack_frame("broadcast frame");
      build_frame(48'h02_00_5e_10_20_31, 50, 1'b0, 1'b0);
      send_frame();
      exp_addr++;
      expect_eq(frame_avail, 0, "frame_avail for foreign address");
      check_counters();
      report_test("address filter", mark);

      mark = errors;
      build_frame(station_mac, 48, 1'b1, 1'b0);
      send_frame();
      build_frame(station_mac, 47, 1'b0, 1'b0);
      send_frame();
      exp_crc += 2;
      expect_eq(frame_avail, 0, "frame_avail for bad frames");
      check_counters();
      report_test("FCS and runt drop", mark);

      mark = errors;
      for (int k = 0; k < 5; k++) begin
         build_frame(station_mac, 50 + k, 1'b0, k < 4);
         send_frame();
      end
      exp_rx += 4;
      exp_full++;
      check_counters();
      for (int k = 0; k < 4; k++) begin
         wait_avail("ring frame");
         read_frame("ring frame");
         ack_frame("ring frame");
      end
      @(negedge RX_CLK);
      expect_eq(frame_avail, 0, "frame_avail with ring empty");
      report_test("ring full and order", mark);

      mark = errors;
      build_frame(station_mac, 48, 1'b0, 1'b1);
      send_frame();
      build_frame(station_mac, 52, 1'b0, 1'b1);
      send_frame();
      wait_avail("first held frame");
      read_frame("first held frame");
      build_frame(station_mac, 60, 1'b0, 1'b1);
      // Ack lands while the third frame is still arriving
      fork
         send_frame();
         begin
            repeat (40) @(negedge RX_CLK);
            ack_frame("first held frame");
         end
      join
      exp_rx += 3;
      wait_avail("second held frame");
      read_frame("second held frame");
      ack_frame("second held frame");
      wait_avail("third frame");
      read_frame("third frame");
      ack_frame("third frame");
      check_counters();
      report_test("ack during receive", mark);

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
